// File: hw/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;    // Eight registers
    localparam int memAddrWidth = 8;
    localparam int imemDepth    = 256;
    localparam int dmemDepth    = 256;

    localparam logic [4:0] opHalt = 5'b00000;
    localparam logic [4:0] opNop  = 5'b00001;
    localparam logic [4:0] opAddi = 5'b01000;
    localparam logic [4:0] opAndi = 5'b01011;
    localparam logic [4:0] opBeqz = 5'b01100;
    localparam logic [4:0] opBnez = 5'b01101;
    localparam logic [4:0] opSt   = 5'b10000;
    localparam logic [4:0] opLd   = 5'b10001;
    localparam logic [4:0] opLbi  = 5'b11000;
    localparam logic [4:0] opAlu  = 5'b11011;

    localparam logic [1:0] fnAdd = 2'b00;
    localparam logic [1:0] fnSub = 2'b01;   // rs minus rt
    localparam logic [1:0] fnXor = 2'b10;
    localparam logic [1:0] fnAnd = 2'b11;

    typedef struct packed {
        logic [4:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [1:0]              funct;
    } rFormatT;

    typedef struct packed {
        logic [4:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              imm5;
    } iFormatT;

    typedef struct packed {
        logic [4:0]              opcode;
        logic [regAddrWidth-1:0] rs;
        logic [7:0]              imm8;
    } bFormatT;

    // One instruction word, three views
    typedef union packed {
        rFormatT r;
        iFormatT i;
        bFormatT b;
    } instrT;

    typedef logic [1:0] fwdSelT;
    localparam fwdSelT fwdReg   = 2'd0;
    localparam fwdSelT fwdExMem = 2'd1;
    localparam fwdSelT fwdMemWb = 2'd2;

endpackage

// File: hw/fetch.sv
`timescale 1ns/1ps
module fetch (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            stall,
    input  logic                            branchTaken,
    input  logic                            haltSeen,
    input  logic [cpuPkg::dataWidth-1:0]    branchTarget,
    input  logic                            progWrEn,
    input  logic [cpuPkg::memAddrWidth-1:0] progAddr,
    input  logic [cpuPkg::dataWidth-1:0]    progData,
    output cpuPkg::instrT                   instr,
    output logic [cpuPkg::dataWidth-1:0]    pcPlus1
);
    import cpuPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcNext;
    logic [dataWidth-1:0] imem [imemDepth];

    always_ff @(posedge clk) begin
        if (progWrEn) begin
            imem[progAddr] <= progData;     // Program load port
        end
    end

    assign instr   = imem[pc[memAddrWidth-1:0]];
    assign pcPlus1 = pc + 1'b1;

    always_comb begin
        if (branchTaken) begin
            pcNext = branchTarget;
        end else if (stall || haltSeen) begin
            pcNext = pc;                    // Hold on stall or after halt
        end else begin
            pcNext = pcPlus1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: hw/decode.sv
`timescale 1ns/1ps
module decode (
    input  logic                            clk,
    input  logic                            rstN,
    input  cpuPkg::instrT                   instr,
    input  logic [cpuPkg::dataWidth-1:0]    pcPlus1,
    input  logic                            valid,
    input  logic                            wbEn,
    input  logic [cpuPkg::regAddrWidth-1:0] wbAddr,
    input  logic [cpuPkg::dataWidth-1:0]    wbData,
    output logic [cpuPkg::dataWidth-1:0]    rsVal,
    output logic [cpuPkg::dataWidth-1:0]    rtVal,
    output logic [cpuPkg::dataWidth-1:0]    imm,
    output logic [cpuPkg::regAddrWidth-1:0] rsAddr,
    output logic [cpuPkg::regAddrWidth-1:0] rtAddr,
    output logic [cpuPkg::regAddrWidth-1:0] destAddr,
    output logic                            useRs,
    output logic                            useRt,
    output logic                            regWrite,
    output logic                            memRead,
    output logic                            memWrite,
    output logic                            isHalt,
    output logic                            illegal,
    output logic [1:0]                      aluOp,
    output logic                            aluSrcImm,
    output logic                            branchTaken,
    output logic [cpuPkg::dataWidth-1:0]    branchTarget
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [1 << regAddrWidth];
    logic [dataWidth-1:0] rsRaw;
    logic                 isLbi;
    logic                 isBranch;
    logic                 rsZero;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < (1 << regAddrWidth); k++) begin
                regs[k] <= '0;
            end
        end else if (wbEn) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        useRs     = 1'b0;
        useRt     = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        isHalt    = 1'b0;
        illegal   = 1'b0;
        isLbi     = 1'b0;
        isBranch  = 1'b0;
        aluOp     = fnAdd;
        aluSrcImm = 1'b1;
        rtAddr    = instr.r.rt;
        destAddr  = instr.i.rd;
        imm       = {{(dataWidth-5){instr.i.imm5[4]}}, instr.i.imm5};
        case (instr.r.opcode)
            opHalt: isHalt = 1'b1;
            opNop:  ;                           // Nothing to do
            opAlu: begin
                useRs     = 1'b1;
                useRt     = 1'b1;
                regWrite  = 1'b1;
                aluOp     = instr.r.funct;
                aluSrcImm = 1'b0;
                destAddr  = instr.r.rd;
            end
            opAddi: begin
                useRs    = 1'b1;
                regWrite = 1'b1;
            end
            opAndi: begin
                useRs    = 1'b1;
                regWrite = 1'b1;
                aluOp    = fnAnd;
                imm      = {{(dataWidth-5){1'b0}}, instr.i.imm5};
            end
            opLd: begin
                useRs    = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            opSt: begin
                useRs    = 1'b1;
                useRt    = 1'b1;
                memWrite = 1'b1;
                rtAddr   = instr.i.rd;          // Store data sits in the rd field
            end
            opBeqz, opBnez: begin
                useRs    = 1'b1;
                isBranch = 1'b1;
                imm      = {{(dataWidth-8){instr.b.imm8[7]}}, instr.b.imm8};
            end
            opLbi: begin
                isLbi    = 1'b1;
                regWrite = 1'b1;
                destAddr = instr.b.rs;
                imm      = {{(dataWidth-8){instr.b.imm8[7]}}, instr.b.imm8};
            end
            default: illegal = 1'b1;
        endcase
    end

    // Same-cycle writeback passes straight to the reads
    assign rsAddr = instr.r.rs;
    assign rsRaw  = (wbEn && wbAddr == rsAddr) ? wbData : regs[rsAddr];
    assign rtVal  = (wbEn && wbAddr == rtAddr) ? wbData : regs[rtAddr];
    assign rsVal  = isLbi ? '0 : rsRaw;     // LBI adds imm to zero

    assign rsZero       = (rsRaw == '0);
    assign branchTaken  = valid && isBranch && ((instr.b.opcode == opBeqz) == rsZero);
    assign branchTarget = pcPlus1 + imm;

endmodule

// File: hw/hazardUnit.sv
`timescale 1ns/1ps
module hazardUnit (
    input  logic [cpuPkg::regAddrWidth-1:0] rsAddr,
    input  logic [cpuPkg::regAddrWidth-1:0] rtAddr,
    input  logic                            useRs,
    input  logic                            useRt,
    input  logic                            isBranch,
    input  logic [cpuPkg::regAddrWidth-1:0] exDest,
    input  logic                            exRegWrite,
    input  logic                            exMemRead,
    input  logic [cpuPkg::regAddrWidth-1:0] memDest,
    input  logic                            memRegWrite,
    input  logic [cpuPkg::regAddrWidth-1:0] wbDest,
    input  logic                            wbRegWrite,
    input  logic [cpuPkg::regAddrWidth-1:0] idexRs,
    input  logic [cpuPkg::regAddrWidth-1:0] idexRt,
    output logic                            stall,
    output cpuPkg::fwdSelT                  fwdA,
    output cpuPkg::fwdSelT                  fwdB
);
    import cpuPkg::*;

    logic rsHitEx;
    logic rtHitEx;
    logic rsHitMem;

    function automatic fwdSelT pickFwd(input logic [regAddrWidth-1:0] src);
        if (memRegWrite && memDest == src) begin
            return fwdExMem;                // Youngest producer wins
        end else if (wbRegWrite && wbDest == src) begin
            return fwdMemWb;
        end
        return fwdReg;
    endfunction

    assign rsHitEx  = useRs && (rsAddr == exDest);
    assign rtHitEx  = useRt && (rtAddr == exDest);
    assign rsHitMem = useRs && (rsAddr == memDest);

    // Branches resolve in decode and only see the writeback bypass
    assign stall = (exMemRead && (rsHitEx || rtHitEx))
                || (isBranch && ((exRegWrite && rsHitEx) || (memRegWrite && rsHitMem)));

    assign fwdA = pickFwd(idexRs);
    assign fwdB = pickFwd(idexRt);

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps
module execute (
    input  logic [cpuPkg::dataWidth-1:0] rsVal,
    input  logic [cpuPkg::dataWidth-1:0] rtVal,
    input  logic [cpuPkg::dataWidth-1:0] imm,
    input  logic [1:0]                   aluOp,
    input  logic                         aluSrcImm,
    input  cpuPkg::fwdSelT               fwdA,
    input  cpuPkg::fwdSelT               fwdB,
    input  logic [cpuPkg::dataWidth-1:0] exMemResult,
    input  logic [cpuPkg::dataWidth-1:0] memWbResult,
    output logic [cpuPkg::dataWidth-1:0] aluResult,
    output logic [cpuPkg::dataWidth-1:0] storeData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;

    function automatic logic [dataWidth-1:0] fwdMux(input fwdSelT sel,
                                                    input logic [dataWidth-1:0] regVal);
        case (sel)
            fwdExMem: return exMemResult;
            fwdMemWb: return memWbResult;
            default:  return regVal;
        endcase
    endfunction

    assign opA       = fwdMux(fwdA, rsVal);
    assign storeData = fwdMux(fwdB, rtVal); // Also the R-format second operand
    assign opB       = aluSrcImm ? imm : storeData;

    always_comb begin
        case (aluOp)
            fnAdd:   aluResult = opA + opB;
            fnSub:   aluResult = opA - opB;
            fnXor:   aluResult = opA ^ opB;
            default: aluResult = opA & opB;
        endcase
    end

endmodule

// File: hw/dataMem.sv
`timescale 1ns/1ps
module dataMem (
    input  logic                         clk,
    input  logic [cpuPkg::dataWidth-1:0] addr,
    input  logic [cpuPkg::dataWidth-1:0] writeData,
    input  logic                         memWrite,
    input  logic                         memRead,
    output logic [cpuPkg::dataWidth-1:0] readData
);
    import cpuPkg::*;

    logic [dataWidth-1:0] mem [dmemDepth];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[addr[memAddrWidth-1:0]] <= writeData;
        end
    end

    assign readData = memRead ? mem[addr[memAddrWidth-1:0]] : '0;

endmodule

// File: hw/proc.sv
`timescale 1ns/1ps
module proc (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            progWrEn,
    input  logic [cpuPkg::memAddrWidth-1:0] progAddr,
    input  logic [cpuPkg::dataWidth-1:0]    progData,
    output logic                            regWrEn,
    output logic [cpuPkg::regAddrWidth-1:0] regWrAddr,
    output logic [cpuPkg::dataWidth-1:0]    regWrData,
    output logic                            halted,
    output logic                            err
);
    import cpuPkg::*;

    instrT                   ifInstr;
    instrT                   ifidInstr;
    logic [dataWidth-1:0]    ifPcPlus1;
    logic [dataWidth-1:0]    ifidPcPlus1;
    logic                    ifidValid;
    logic                    frontStop;
    logic                    haltSeen;

    logic [dataWidth-1:0]    idRsVal;
    logic [dataWidth-1:0]    idRtVal;
    logic [dataWidth-1:0]    idImm;
    logic [dataWidth-1:0]    branchTarget;
    logic [regAddrWidth-1:0] idRsAddr;
    logic [regAddrWidth-1:0] idRtAddr;
    logic [regAddrWidth-1:0] idDest;
    logic                    idUseRs;
    logic                    idUseRt;
    logic                    idRegWrite;
    logic                    idMemRead;
    logic                    idMemWrite;
    logic                    idHalt;
    logic                    idIllegal;
    logic [1:0]              idAluOp;
    logic                    idAluSrcImm;
    logic                    idBranchTaken;
    logic                    idIsBranch;
    logic                    branchTaken;
    logic                    stall;
    fwdSelT                  fwdA;
    fwdSelT                  fwdB;

    logic                    idexValid;
    logic [dataWidth-1:0]    idexRsVal;
    logic [dataWidth-1:0]    idexRtVal;
    logic [dataWidth-1:0]    idexImm;
    logic [regAddrWidth-1:0] idexRs;
    logic [regAddrWidth-1:0] idexRt;
    logic [regAddrWidth-1:0] idexDest;
    logic                    idexUseRs;
    logic                    idexRegWrite;
    logic                    idexMemRead;
    logic                    idexMemWrite;
    logic                    idexHalt;
    logic                    idexIllegal;
    logic [1:0]              idexAluOp;
    logic                    idexAluSrcImm;
    logic [dataWidth-1:0]    exAluResult;
    logic [dataWidth-1:0]    exStoreData;

    logic                    exmemValid;
    logic [dataWidth-1:0]    exmemAlu;
    logic [dataWidth-1:0]    exmemStore;
    logic [regAddrWidth-1:0] exmemDest;
    logic                    exmemRegWrite;
    logic                    exmemMemRead;
    logic                    exmemMemWrite;
    logic                    exmemHalt;
    logic                    exmemIllegal;
    logic [dataWidth-1:0]    memReadData;

    logic                    memwbValid;
    logic [dataWidth-1:0]    memwbAlu;
    logic [dataWidth-1:0]    memwbReadData;
    logic [regAddrWidth-1:0] memwbDest;
    logic                    memwbRegWrite;
    logic                    memwbMemRead;
    logic [dataWidth-1:0]    wbData;

    // Sticky once a halt or bad opcode leaves decode
    assign haltSeen    = frontStop || (ifidValid && (idHalt || idIllegal));
    assign idIsBranch  = ifidValid && (ifidInstr.b.opcode == opBeqz
                                    || ifidInstr.b.opcode == opBnez);
    assign branchTaken = idBranchTaken && !stall;   // Operand may still be in flight

    fetch fetchStage (
        .clk(clk), .rstN(rstN), .stall(stall), .branchTaken(branchTaken),
        .haltSeen(haltSeen), .branchTarget(branchTarget),
        .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
        .instr(ifInstr), .pcPlus1(ifPcPlus1)
    );

    decode decodeStage (
        .clk(clk), .rstN(rstN), .instr(ifidInstr), .pcPlus1(ifidPcPlus1),
        .valid(ifidValid), .wbEn(regWrEn), .wbAddr(memwbDest), .wbData(wbData),
        .rsVal(idRsVal), .rtVal(idRtVal), .imm(idImm),
        .rsAddr(idRsAddr), .rtAddr(idRtAddr), .destAddr(idDest),
        .useRs(idUseRs), .useRt(idUseRt), .regWrite(idRegWrite),
        .memRead(idMemRead), .memWrite(idMemWrite), .isHalt(idHalt),
        .illegal(idIllegal), .aluOp(idAluOp), .aluSrcImm(idAluSrcImm),
        .branchTaken(idBranchTaken), .branchTarget(branchTarget)
    );

    hazardUnit hazards (
        .rsAddr(idRsAddr), .rtAddr(idRtAddr),
        .useRs(ifidValid && idUseRs), .useRt(ifidValid && idUseRt), .isBranch(idIsBranch),
        .exDest(idexDest), .exRegWrite(idexValid && idexRegWrite),
        .exMemRead(idexValid && idexMemRead),
        .memDest(exmemDest), .memRegWrite(exmemValid && exmemRegWrite),
        .wbDest(memwbDest), .wbRegWrite(regWrEn),
        .idexRs(idexRs), .idexRt(idexRt),
        .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    execute executeStage (
        .rsVal(idexRsVal), .rtVal(idexRtVal), .imm(idexImm),
        .aluOp(idexAluOp), .aluSrcImm(idexAluSrcImm),
        .fwdA(idexUseRs ? fwdA : fwdReg), .fwdB(fwdB),  // LBI keeps its zero operand
        .exMemResult(exmemAlu), .memWbResult(wbData),
        .aluResult(exAluResult), .storeData(exStoreData)
    );

    dataMem dataMemory (
        .clk(clk), .addr(exmemAlu), .writeData(exmemStore),
        .memWrite(exmemValid && exmemMemWrite), .memRead(exmemValid && exmemMemRead),
        .readData(memReadData)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ifidValid  <= 1'b0;
            idexValid  <= 1'b0;
            exmemValid <= 1'b0;
            memwbValid <= 1'b0;
            frontStop  <= 1'b0;
            halted     <= 1'b0;
            err        <= 1'b0;
        end else begin
            if (!stall) begin
                ifidValid <= !branchTaken && !haltSeen;     // Squash the slot behind
            end
            idexValid  <= ifidValid && !stall;              // Bubble on stall
            exmemValid <= idexValid;
            memwbValid <= exmemValid;
            frontStop  <= haltSeen;
            if (exmemValid && (exmemHalt || exmemIllegal)) begin
                halted <= 1'b1;
            end
            if (exmemValid && exmemIllegal) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifidInstr   <= ifInstr;
            ifidPcPlus1 <= ifPcPlus1;
        end
        idexRsVal     <= idRsVal;
        idexRtVal     <= idRtVal;
        idexImm       <= idImm;
        idexRs        <= idRsAddr;
        idexRt        <= idRtAddr;
        idexDest      <= idDest;
        idexUseRs     <= idUseRs;
        idexRegWrite  <= idRegWrite;
        idexMemRead   <= idMemRead;
        idexMemWrite  <= idMemWrite;
        idexHalt      <= idHalt;
        idexIllegal   <= idIllegal;
        idexAluOp     <= idAluOp;
        idexAluSrcImm <= idAluSrcImm;
        exmemAlu      <= exAluResult;
        exmemStore    <= exStoreData;
        exmemDest     <= idexDest;
        exmemRegWrite <= idexRegWrite;
        exmemMemRead  <= idexMemRead;
        exmemMemWrite <= idexMemWrite;
        exmemHalt     <= idexHalt;
        exmemIllegal  <= idexIllegal;
        memwbAlu      <= exmemAlu;
        memwbReadData <= memReadData;
        memwbDest     <= exmemDest;
        memwbRegWrite <= exmemRegWrite;
        memwbMemRead  <= exmemMemRead;
    end

    assign wbData    = memwbMemRead ? memwbReadData : memwbAlu;
    assign regWrEn   = memwbValid && memwbRegWrite;
    assign regWrAddr = memwbDest;
    assign regWrData = wbData;

endmodule

// File: sim/procTb.sv
`timescale 1ns/1ps
module procTb;
    import cpuPkg::*;

    localparam int         haltTimeout = 400;
    localparam int         drainCycles = 8;
    localparam logic [4:0] badOpcode   = 5'b11111;  // Not in the ISA

    logic                    clk = 1'b0;
    logic                    rstN;
    logic                    progWrEn;
    logic [memAddrWidth-1:0] progAddr;
    logic [dataWidth-1:0]    progData;
    logic                    regWrEn;
    logic [regAddrWidth-1:0] regWrAddr;
    logic [dataWidth-1:0]    regWrData;
    logic                    halted;
    logic                    err;

    logic [15:0] prog [256];
    int          progLen;
    logic [15:0] modelRegs [8];
    logic [15:0] modelMem [256];
    logic [2:0]  expAddr [256];
    logic [15:0] expData [256];
    int          expCount;
    logic        expErr;
    int          retIdx;
    logic        wrSeen;
    logic        rstPrev = 1'b1;
    logic        strobeOk;
    integer      seed = 49564;
    int          errCount;
    int          testsPassed;
    int          testsFailed;

    proc DUT (
        .clk(clk), .rstN(rstN),
        .progWrEn(progWrEn), .progAddr(progAddr), .progData(progData),
        .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
        .halted(halted), .err(err)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        wrSeen <= rstN && regWrEn;      // Strobe that the next edge samples
    end

    always @(posedge clk) begin
        rstPrev <= rstN;
        if (!rstN) begin
            retIdx <= 0;
        end else if (wrSeen) begin
            retIdx <= retIdx + 1;
        end
    end

    assign strobeOk = (retIdx < expCount)
                   && (regWrAddr == expAddr[retIdx[7:0]])
                   && (regWrData == expData[retIdx[7:0]]);

    task automatic reportRetire();
        errCount++;
        if (retIdx >= expCount) begin
            $display("error @%0t: extra retirement r%0d = %h", $time, regWrAddr, regWrData);
        end else begin
            $display("error @%0t: retirement %0d wrote r%0d = %h, expected r%0d = %h",
                     $time, retIdx, regWrAddr, regWrData,
                     expAddr[retIdx[7:0]], expData[retIdx[7:0]]);
        end
    endtask

    resetQuiet: assert property (@(posedge clk) !rstPrev |-> (!regWrEn && !halted && !err))
        else begin
            errCount++;
            $display("error @%0t: status or strobe active around reset", $time);
        end

    retireMatch: assert property (@(posedge clk) disable iff (!rstN) regWrEn |-> strobeOk)
        else reportRetire();

    quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN) halted |-> !regWrEn)
        else begin
            errCount++;
            $display("error @%0t: retirement after halt", $time);
        end

    errHalts: assert property (@(posedge clk) disable iff (!rstN) err |-> halted)
        else begin
            errCount++;
            $display("error @%0t: err high while halted is low", $time);
        end

    haltLast: assert property (@(posedge clk) disable iff (!rstN)
                               $rose(halted) |-> (retIdx == expCount))
        else begin
            errCount++;
            $display("error @%0t: halted rose after %0d of %0d writes", $time, retIdx, expCount);
        end

    function automatic logic [7:0] nextRandom8();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [4:0] nextRandom5();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic logic [15:0] encodeAlu(input logic [1:0] fn, input logic [2:0] rd,
                                              input logic [2:0] rs, input logic [2:0] rt);
        return {opAlu, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeI(input logic [4:0] op, input logic [2:0] rd,
                                            input logic [2:0] rs, input logic [4:0] imm5);
        return {op, rs, rd, imm5};
    endfunction

    function automatic logic [15:0] encodeB(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [7:0] imm8);
        return {op, rs, imm8};
    endfunction

    task automatic clearProgram();
        for (int k = 0; k < 256; k++) begin
            prog[k] = '0;                   // HALT
        end
        progLen = 0;
    endtask

    task automatic appendInstr(input logic [15:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic recordWrite(input logic [2:0] a, input logic [15:0] v);
        modelRegs[a]       = v;
        expAddr[expCount]  = a;
        expData[expCount]  = v;
        expCount++;
    endtask

    // Architectural model, one instruction per step
    task automatic runModel();
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] s5;
        logic [15:0] s8;
        logic [15:0] addr;
        logic        done;
        int          steps;
        pc       = '0;
        done     = 1'b0;
        steps    = 0;
        expCount = 0;
        expErr   = 1'b0;
        for (int k = 0; k < 8; k++) begin
            modelRegs[k] = '0;
        end
        while (!done && steps < 1000) begin
            w    = prog[pc[7:0]];
            a    = modelRegs[w[10:8]];
            b    = modelRegs[w[7:5]];
            s5   = {{11{w[4]}}, w[4:0]};
            s8   = {{8{w[7]}}, w[7:0]};
            addr = a + s5;
            pc   = pc + 16'd1;
            case (w[15:11])
                opHalt: done = 1'b1;
                opNop:  ;
                opAlu: begin
                    case (w[1:0])
                        fnAdd: recordWrite(w[4:2], a + b);
                        fnSub: recordWrite(w[4:2], a - b);
                        fnAnd: recordWrite(w[4:2], a & b);
                        fnXor: recordWrite(w[4:2], a ^ b);
                    endcase
                end
                opAddi: recordWrite(w[7:5], a + s5);
                opAndi: recordWrite(w[7:5], a & {11'd0, w[4:0]});
                opLd:   recordWrite(w[7:5], modelMem[addr[7:0]]);
                opSt:   modelMem[addr[7:0]] = b;    // Data from the rd field
                opBeqz: if (a == '0) pc = pc + s8;
                opBnez: if (a != '0) pc = pc + s8;
                opLbi:  recordWrite(w[10:8], s8);
                default: begin
                    done   = 1'b1;
                    expErr = 1'b1;
                end
            endcase
            steps++;
        end
    endtask

    task automatic runTest(input string name);
        int errBefore;
        int cycles;
        errBefore = errCount;
        @(posedge clk);
        #1;
        rstN = 1'b0;
        runModel();
        for (int k = 0; k < progLen + 2; k++) begin
            progWrEn = 1'b1;
            progAddr = k[7:0];
            progData = prog[k];
            @(posedge clk);
            #1;
        end
        progWrEn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN   = 1'b1;
        cycles = 0;
        while (!halted && cycles < haltTimeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            errCount++;
            $display("Timeout: test %s did not halt within %0d cycles", name, haltTimeout);
        end
        repeat (drainCycles) @(posedge clk);   // Window for late strobes
        #1;
        assert (retIdx == expCount) else begin
            errCount++;
            $display("error @%0t: %s retired %0d writes, expected %0d",
                     $time, name, retIdx, expCount);
        end
        assert (err == expErr) else begin
            errCount++;
            $display("error @%0t: %s err is %0b, expected %0b", $time, name, err, expErr);
        end
        if (errCount == errBefore) begin
            testsPassed++;
            $display("Test %s passed, %0d writes", name, expCount);
        end else begin
            testsFailed++;
            $display("Test %s failed, %0d errors", name, errCount - errBefore);
        end
    endtask

    task automatic buildResetProgram();
        clearProgram();
        appendInstr(encodeB(opNop, 3'd0, 8'd0));
        appendInstr(encodeB(opLbi, 3'd1, 8'h5a));
        appendInstr(encodeB(opHalt, 3'd0, 8'd0));
    endtask

    task automatic buildAluChain();
        clearProgram();
        appendInstr(encodeB(opLbi, 3'd1, nextRandom8()));
        appendInstr(encodeB(opLbi, 3'd2, nextRandom8()));
        appendInstr(encodeB(opLbi, 3'd3, nextRandom8()));
        appendInstr(encodeAlu(fnAdd, 3'd4, 3'd1, 3'd2));
        appendInstr(encodeAlu(fnSub, 3'd5, 3'd4, 3'd3));   // r4 from EX/MEM
        appendInstr(encodeAlu(fnAnd, 3'd6, 3'd2, 3'd5));   // Forward into rt
        appendInstr(encodeAlu(fnXor, 3'd7, 3'd6, 3'd5));   // r5 from MEM/WB
        appendInstr(encodeI(opAddi, 3'd0, 3'd7, nextRandom5()));
        appendInstr(encodeI(opAndi, 3'd1, 3'd0, nextRandom5()));
        appendInstr(encodeAlu(fnSub, 3'd2, 3'd1, 3'd0));
        appendInstr(encodeB(opHalt, 3'd0, 8'd0));
    endtask

    task automatic buildMemProgram();
        clearProgram();
        appendInstr(encodeB(opLbi, 3'd1, nextRandom8()));  // Base address
        appendInstr(encodeB(opLbi, 3'd2, nextRandom8()));
        appendInstr(encodeB(opLbi, 3'd3, nextRandom8()));
        appendInstr(encodeI(opSt, 3'd2, 3'd1, 5'd0));
        appendInstr(encodeI(opSt, 3'd3, 3'd1, 5'd1));
        appendInstr(encodeI(opLd, 3'd4, 3'd1, 5'd0));
        appendInstr(encodeAlu(fnAdd, 3'd5, 3'd4, 3'd2));   // Load-use on rs
        appendInstr(encodeI(opLd, 3'd6, 3'd1, 5'd1));
        appendInstr(encodeAlu(fnAdd, 3'd7, 3'd3, 3'd6));   // Load-use on rt
        appendInstr(encodeI(opLd, 3'd0, 3'd1, 5'd1));
        appendInstr(encodeI(opSt, 3'd0, 3'd1, 5'd2));      // Loaded store data
        appendInstr(encodeI(opLd, 3'd4, 3'd1, 5'd2));
        appendInstr(encodeAlu(fnAdd, 3'd5, 3'd4, 3'd5));
        appendInstr(encodeB(opHalt, 3'd0, 8'd0));
    endtask

    task automatic buildBranchProgram();
        clearProgram();
        appendInstr(encodeB(opLbi, 3'd1, 8'd0));
        appendInstr(encodeB(opLbi, 3'd2, nextRandom8() | 8'h01));
        appendInstr(encodeB(opBeqz, 3'd1, 8'd1));          // Taken
        appendInstr(encodeB(opLbi, 3'd3, 8'd11));
        appendInstr(encodeB(opLbi, 3'd3, 8'd22));
        appendInstr(encodeB(opBnez, 3'd1, 8'd1));          // Not taken
        appendInstr(encodeB(opLbi, 3'd4, 8'd33));
        appendInstr(encodeB(opBnez, 3'd2, 8'd2));          // Taken, skips two
        appendInstr(encodeB(opLbi, 3'd5, 8'd44));
        appendInstr(encodeB(opLbi, 3'd5, 8'd55));
        appendInstr(encodeI(opAddi, 3'd6, 3'd2, 5'h1f));
        appendInstr(encodeI(opAddi, 3'd7, 3'd1, 5'd0));
        appendInstr(encodeB(opBeqz, 3'd7, 8'd1));          // Producer just before
        appendInstr(encodeB(opLbi, 3'd0, 8'd66));
        appendInstr(encodeI(opSt, 3'd2, 3'd1, 5'd5));
        appendInstr(encodeI(opLd, 3'd4, 3'd1, 5'd5));
        appendInstr(encodeB(opBeqz, 3'd4, 8'd1));          // Operand from a load
        appendInstr(encodeB(opLbi, 3'd0, 8'd77));
        appendInstr(encodeB(opLbi, 3'd3, 8'd3));
        appendInstr(encodeI(opAddi, 3'd3, 3'd3, 5'h1f));   // Loop body
        appendInstr(encodeB(opBnez, 3'd3, 8'hfe));         // Back to the ADDI
        appendInstr(encodeB(opHalt, 3'd0, 8'd0));
    endtask

    task automatic buildIllegalProgram();
        clearProgram();
        appendInstr(encodeB(opLbi, 3'd1, nextRandom8()));
        appendInstr(encodeI(opAddi, 3'd2, 3'd1, nextRandom5()));
        appendInstr(encodeAlu(fnAdd, 3'd3, 3'd1, 3'd2));
        appendInstr({badOpcode, 3'd4, nextRandom8()});
        appendInstr(encodeB(opLbi, 3'd4, 8'd5));
        appendInstr(encodeI(opAddi, 3'd5, 3'd4, 5'd1));
        appendInstr(encodeB(opHalt, 3'd0, 8'd0));
    endtask

    initial begin
        rstN        = 1'b0;
        progWrEn    = 1'b0;
        progAddr    = '0;
        progData    = '0;
        errCount    = 0;
        testsPassed = 0;
        testsFailed = 0;
        expCount    = 0;
        expErr      = 1'b0;
        progLen     = 0;

        buildResetProgram();
        runTest("reset");
        buildAluChain();
        runTest("alu chain");
        buildMemProgram();
        runTest("store load");
        buildBranchProgram();
        runTest("branches");
        buildIllegalProgram();
        runTest("illegal opcode");

        $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errCount);
        if (testsFailed == 0 && errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
hw/cpuPkg.sv
hw/fetch.sv
hw/decode.sv
hw/hazardUnit.sv
hw/execute.sv
hw/dataMem.sv
hw/proc.sv
sim/procTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= procTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= All checks passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
